// ==== Makefile ====
# Verilator build and run of the vector datapath slice testbench

VERILATOR ?= verilator
TOP ?= vector_core_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Regression passed
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
+incdir+verilog
verilog/vector_pkg.sv
verilog/instr_pkg.sv
verilog/operand_decode.sv
verilog/vector_register_file.sv
verilog/vector_lane_alu.sv
verilog/vector_core_top.sv
verif/vector_core_checker.sv
verif/vector_core_tb.sv

// ==== verif/vector_core_checker.sv ====
// Vector slice pipeline checker
// Concurrent assertions on the issue and commit strobes and on the
// register-file write enable, bound into the slice top level.

`timescale 1ns/1ps
`default_nettype none

module vector_core_checker
(
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_valid,
	input wire logic [31:0] issue_instr,
	input wire logic commit_valid,
	input wire logic write_enable
);

	logic legal_issue;
	logic illegal_issue;

	// the opcode sits in bits 30 to 27 in both formats
	assign legal_issue = issue_valid && (issue_instr[30:27] <= 4'd7);
	assign illegal_issue = issue_valid && (issue_instr[30:27] > 4'd7);

	a_write_enable_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(write_enable))
		else $error("write enable is unknown after reset");

	a_legal_commits: assert property (@(posedge clk) disable iff (rst)
		legal_issue |-> ##2 commit_valid)
		else $error("a legal issue did not commit two edges later");

	a_illegal_dropped: assert property (@(posedge clk) disable iff (rst)
		illegal_issue |-> ##2 !commit_valid)
		else $error("an illegal opcode produced a commit");

endmodule

bind vector_core_top vector_core_checker u_vector_core_checker
(
	.clk(clk),
	.rst(rst),
	.issue_valid(issue_valid),
	.issue_instr(issue_instr),
	.commit_valid(commit_valid),
	.write_enable(wb_valid)
);

`default_nettype wire

// ==== verif/vector_core_tb.sv ====
// Vector datapath slice testbench
// Runs strand isolation, every opcode in both formats, lane masking,
// back-to-back dependences and illegal opcodes through the slice.
// Expected commits are queued at issue time from a model register array
// and a separate process checks each commit against them.

`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module vector_core_tb;

	localparam int INIT_ISSUES = 2 * `VEC_NUM_REGS;
	localparam int MASK_WRITES = 40;
	localparam int MASK_REGS = 8;
	localparam int OP_ISSUES = 64;
	localparam int HAZARD_ISSUES = 9;
	localparam int ILLEGAL_COUNT = 4;
	localparam int TOTAL_ISSUES = INIT_ISSUES + MASK_WRITES + MASK_REGS + OP_ISSUES
		+ HAZARD_ISSUES + 2 * ILLEGAL_COUNT;
	localparam int CYCLE_LIMIT = TOTAL_ISSUES + 50;

	logic clk;
	logic rst;
	logic issue_valid;
	logic [`VEC_STRAND_W-1:0] issue_strand;
	instr_pkg::vec_instr_u issue_instr;
	vector_pkg::lane_mask_t issue_mask;
	logic commit_valid;
	vector_pkg::reg_idx_t commit_reg;
	vector_pkg::vector_t commit_value;
	vector_pkg::lane_mask_t commit_mask;

	// model registers, and writes in flight (0 is the issue being driven now)
	vector_pkg::vector_t model_regs [0:`VEC_NUM_REGS-1];
	logic pend_valid [0:2];
	vector_pkg::reg_idx_t pend_reg [0:2];
	vector_pkg::vector_t pend_value [0:2];
	vector_pkg::lane_mask_t pend_mask [0:2];

	string exp_name_q [$];
	vector_pkg::reg_idx_t exp_reg_q [$];
	vector_pkg::vector_t exp_value_q [$];
	vector_pkg::lane_mask_t exp_mask_q [$];

	int cycle_count;

	vector_core_top u_vector_core_top
	(
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue_strand(issue_strand),
		.issue_instr(issue_instr),
		.issue_mask(issue_mask),
		.commit_valid(commit_valid),
		.commit_reg(commit_reg),
		.commit_value(commit_value),
		.commit_mask(commit_mask)
	);

	always #50 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// lane-wise result of one opcode, b already holds the broadcast immediate
	function automatic vector_pkg::vector_t expected_result(input logic [3:0] op,
		input vector_pkg::vector_t a, input vector_pkg::vector_t b);
		vector_pkg::vector_t r;
		for (int i = 0; i < `VEC_NUM_LANES; i++)
		begin
			case (op)
				instr_pkg::OP_ADD:  r[i] = a[i] + b[i];
				instr_pkg::OP_SUB:  r[i] = a[i] - b[i];
				instr_pkg::OP_AND:  r[i] = a[i] & b[i];
				instr_pkg::OP_OR:   r[i] = a[i] | b[i];
				instr_pkg::OP_XOR:  r[i] = a[i] ^ b[i];
				instr_pkg::OP_MOVE: r[i] = b[i];
				instr_pkg::OP_SHL:  r[i] = a[i] << b[i][4:0];
				instr_pkg::OP_SLT:  r[i] = ($signed(a[i]) < $signed(b[i])) ? 32'd1 : 32'd0;
				default:            r[i] = '0;
			endcase
		end
		return r;
	endfunction

	function automatic vector_pkg::vector_t merge_lanes(input vector_pkg::vector_t old_value,
		input vector_pkg::vector_t new_value, input vector_pkg::lane_mask_t mask);
		vector_pkg::vector_t r;
		for (int i = 0; i < `VEC_NUM_LANES; i++)
			r[i] = mask[i] ? new_value[i] : old_value[i];
		return r;
	endfunction

	// a write lands two edges after its issue, after that edge's reads
	task automatic next_edge();
		@(posedge clk);
		if (pend_valid[2])
			model_regs[pend_reg[2]] = merge_lanes(model_regs[pend_reg[2]], pend_value[2],
				pend_mask[2]);
		for (int i = 2; i > 0; i--)
		begin
			pend_valid[i] = pend_valid[i-1];
			pend_reg[i] = pend_reg[i-1];
			pend_value[i] = pend_value[i-1];
			pend_mask[i] = pend_mask[i-1];
		end
		pend_valid[0] = 1'b0;
		#1;
	endtask

	task automatic idle_cycles(input int n);
		issue_valid = 1'b0;
		repeat (n) next_edge();
	endtask

	task automatic issue_op(input string name, input logic [1:0] strand, input logic fmt,
		input logic [3:0] op, input logic [4:0] dest, input logic [4:0] src1,
		input logic [4:0] src2, input logic [16:0] imm, input vector_pkg::lane_mask_t mask);
		vector_pkg::lane_t imm_lane;
		vector_pkg::vector_t b;
		vector_pkg::vector_t result;
		imm_lane = {{15{imm[16]}}, imm};
		b = fmt ? {`VEC_NUM_LANES{imm_lane}} : model_regs[{strand, src2}];
		result = expected_result(op, model_regs[{strand, src1}], b);
		issue_valid = 1'b1;
		issue_strand = strand;
		issue_mask = mask;
		if (fmt)
			issue_instr = {1'b1, op, dest, src1, imm};
		else
			issue_instr = {1'b0, op, dest, src1, src2, 12'h000};
		// unassigned opcodes are dropped, so nothing comes back for them
		if (op < 4'd8)
		begin
			exp_name_q.push_back(name);
			exp_reg_q.push_back({strand, dest});
			exp_value_q.push_back(result);
			exp_mask_q.push_back(mask);
			pend_valid[0] = 1'b1;
			pend_reg[0] = {strand, dest};
			pend_value[0] = result;
			pend_mask[0] = mask;
		end
		next_edge();
	endtask

	task automatic compare_commit();
		string name;
		vector_pkg::reg_idx_t e_reg;
		vector_pkg::vector_t e_value;
		vector_pkg::lane_mask_t e_mask;
		name = exp_name_q.pop_front();
		e_reg = exp_reg_q.pop_front();
		e_value = exp_value_q.pop_front();
		e_mask = exp_mask_q.pop_front();
		assert (commit_reg == e_reg && commit_mask == e_mask && commit_value == e_value)
		else
			fail_run($sformatf("ERR %s expected reg %0d mask %h value %h actual reg %0d mask %h value %h",
				name, e_reg, e_mask, e_value, commit_reg, commit_mask, commit_value));
	endtask

	// commit outputs change just after the rising edge, so sample them midway
	always @(negedge clk)
	begin
		if (!rst && commit_valid)
		begin
			assert (exp_name_q.size() != 0) compare_commit();
			else fail_run("a commit appeared while no instruction was outstanding");
		end
	end

	always @(posedge clk)
	begin
		if (rst)
			cycle_count <= 0;
		else
		begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= CYCLE_LIMIT)
				fail_run("timeout: the tests did not finish within the cycle limit");
		end
	end

	initial
	begin
		vector_pkg::lane_mask_t mask;
		void'($urandom(83));
		clk = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_strand = '0;
		issue_instr = '0;
		issue_mask = '0;
		for (int i = 0; i < `VEC_NUM_REGS; i++)
			model_regs[i] = '0;
		for (int i = 0; i < 3; i++)
			pend_valid[i] = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		idle_cycles(4);

		// strand number sits in the top immediate bits, so every register differs
		for (int s = 0; s < `VEC_NUM_STRANDS; s++)
			for (int r = 0; r < `VEC_REGS_PER_STRAND; r++)
				issue_op("init", 2'(s), 1'b1, instr_pkg::OP_MOVE, 5'(r), 5'(r), 5'(r),
					{2'(s), 5'(r), 10'($urandom())}, '1);
		for (int s = 0; s < `VEC_NUM_STRANDS; s++)
			for (int r = 0; r < `VEC_REGS_PER_STRAND; r++)
				issue_op("strands", 2'(s), 1'b0, instr_pkg::OP_MOVE, 5'(r), 5'(r), 5'(r),
					17'h0, '1);

		for (int i = 0; i < MASK_WRITES; i++)
		begin
			mask = (i == 0) ? '0 : (i == 1) ? '1 : 16'($urandom());
			issue_op("masks", 2'd1, 1'b1, instr_pkg::OP_MOVE, 5'($urandom() % MASK_REGS),
				5'd0, 5'd0, 17'($urandom()), mask);
		end
		for (int r = 0; r < MASK_REGS; r++)
			issue_op("masks", 2'd1, 1'b0, instr_pkg::OP_MOVE, 5'(r), 5'(r), 5'(r), 17'h0, '1);

		for (int rep = 0; rep < OP_ISSUES / 16; rep++)
			for (int op = 0; op < 8; op++)
				for (int fmt = 0; fmt < 2; fmt++)
					issue_op("opcodes", 2'($urandom()), 1'(fmt), 4'(op), 5'($urandom()),
						5'($urandom()), 5'($urandom()), 17'($urandom()), 16'($urandom()));

		// a consumer d cycles behind its producer sees the new value only from d = 3
		for (int d = 1; d <= 3; d++)
		begin
			issue_op("hazard", 2'd2, 1'b1, instr_pkg::OP_MOVE, 5'd5, 5'd0, 5'd0,
				17'($urandom()), '1);
			for (int f = 1; f < d; f++)
				issue_op("hazard", 2'd3, 1'b1, instr_pkg::OP_MOVE, 5'd0, 5'd0, 5'd0,
					17'($urandom()), '1);
			issue_op("hazard", 2'd2, 1'b0, instr_pkg::OP_ADD, 5'd6, 5'd5, 5'd5, 17'h0, '1);
		end

		for (int i = 0; i < ILLEGAL_COUNT; i++)
			issue_op("illegal", 2'd0, 1'($urandom()), {1'b1, 3'($urandom())}, 5'(i), 5'(i),
				5'(i), 17'($urandom()), '1);
		idle_cycles(2);
		for (int r = 0; r < ILLEGAL_COUNT; r++)
			issue_op("illegal", 2'd0, 1'b0, instr_pkg::OP_MOVE, 5'(r), 5'(r), 5'(r), 17'h0, '1);
		idle_cycles(4);

		if (exp_name_q.size() != 0)
			fail_run("some expected commits never appeared on the commit outputs");
		else
		begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/instr_pkg.sv ====
// Vector instruction encoding
// Opcode set and the two layouts of the 32-bit instruction word. Bit 31
// picks the layout: 0 for register-register, 1 for register-immediate.
// Both layouts keep opcode, dest and src1 at the same bit positions.

`default_nettype none

`include "vector_cfg.svh"

package instr_pkg;

	// codes 8 to 15 are not assigned and are dropped at decode
	typedef enum logic [3:0]
	{
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_MOVE = 4'd5,
		OP_SHL  = 4'd6,
		OP_SLT  = 4'd7
	} vec_op_t;

	typedef struct packed
	{
		logic fmt;
		vec_op_t op;
		logic [`VEC_ARCH_REG_W-1:0] dest;
		logic [`VEC_ARCH_REG_W-1:0] src1;
		logic [`VEC_ARCH_REG_W-1:0] src2;
		logic [11:0] unused;
	} rr_fmt_t;

	// the immediate takes the place of src2 and the spare bits
	typedef struct packed
	{
		logic fmt;
		vec_op_t op;
		logic [`VEC_ARCH_REG_W-1:0] dest;
		logic [`VEC_ARCH_REG_W-1:0] src1;
		logic signed [16:0] imm;
	} ri_fmt_t;

	typedef union packed
	{
		rr_fmt_t rr;
		ri_fmt_t ri;
	} vec_instr_u;

endpackage

`default_nettype wire

// ==== verilog/operand_decode.sv ====
// Operand decode stage
// Splits the issued instruction word into register-file read selects,
// which go out combinationally, and a registered control bundle that
// meets the registered operands in the execute stage one edge later.
// Words with an unassigned opcode never raise ex_valid.

`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module operand_decode
(
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_valid,
	input wire logic [`VEC_STRAND_W-1:0] issue_strand,
	input instr_pkg::vec_instr_u issue_instr,
	input vector_pkg::lane_mask_t issue_mask,
	output vector_pkg::reg_idx_t read_sel1,
	output vector_pkg::reg_idx_t read_sel2,
	output logic ex_valid,
	output instr_pkg::vec_op_t ex_op,
	output vector_pkg::reg_idx_t ex_dest,
	output vector_pkg::lane_mask_t ex_mask,
	output logic ex_use_imm,
	output vector_pkg::lane_t ex_imm
);

	localparam int IMM_W = $bits(issue_instr.ri.imm);

	logic use_imm;
	instr_pkg::vec_op_t op;
	logic op_legal;
	logic [`VEC_ARCH_REG_W-1:0] arch_dest;
	logic [`VEC_ARCH_REG_W-1:0] arch_src1;
	vector_pkg::lane_t imm_ext;

	// bit 31 tells which view of the word is the real one
	assign use_imm = issue_instr.ri.fmt;

	// opcode, dest and src1 sit at the same bits in both layouts
	assign op = issue_instr.rr.op;
	assign arch_dest = issue_instr.rr.dest;
	assign arch_src1 = issue_instr.rr.src1;

	// only the low eight codes are assigned
	assign op_legal = (op <= instr_pkg::OP_SLT);

	assign imm_ext = {{(`VEC_LANE_WIDTH - IMM_W){issue_instr.ri.imm[IMM_W-1]}},
		issue_instr.ri.imm};

	// strand number forms the upper index bits, so strands never alias
	assign read_sel1 = {issue_strand, arch_src1};

	// in the immediate format the src2 field is immediate bits and this
	// read result is ignored by the ALU
	assign read_sel2 = {issue_strand, issue_instr.rr.src2};

	always_ff @(posedge clk)
	begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= issue_valid && op_legal;
	end

	always_ff @(posedge clk)
	begin
		ex_op <= op;
		ex_dest <= {issue_strand, arch_dest};
		ex_mask <= issue_mask;
		ex_use_imm <= use_imm;
		ex_imm <= imm_ext;
	end

endmodule

`default_nettype wire

// ==== verilog/vector_cfg.svh ====
// Vector slice configuration
// Lane geometry, strand count and register-file sizing shared by the
// packages and the datapath modules. Index widths are derived here so
// the whole slice resizes from the values at the top.

`ifndef VECTOR_CFG_SVH
`define VECTOR_CFG_SVH

// lane geometry of one vector register
`define VEC_NUM_LANES 16
`define VEC_LANE_WIDTH 32

// hardware strands and architectural registers visible to each one
`define VEC_NUM_STRANDS 4
`define VEC_REGS_PER_STRAND 32

// physical register file holds every strand's registers side by side
`define VEC_NUM_REGS (`VEC_NUM_STRANDS * `VEC_REGS_PER_STRAND)

`define VEC_REG_IDX_W $clog2(`VEC_NUM_REGS)
`define VEC_STRAND_W $clog2(`VEC_NUM_STRANDS)
`define VEC_ARCH_REG_W $clog2(`VEC_REGS_PER_STRAND)

`endif

// ==== verilog/vector_core_top.sv ====
// Vector datapath slice
// Decode, register read, lane-wise execute and masked write-back for a
// four-strand SIMD core. An issue at one edge shows on the commit ports
// after the next edge and lands in the register file one edge later.
// There is no forwarding and no back-pressure.

`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module vector_core_top
(
	input wire logic clk,
	input wire logic rst,
	input wire logic issue_valid,
	input wire logic [`VEC_STRAND_W-1:0] issue_strand,
	input instr_pkg::vec_instr_u issue_instr,
	input vector_pkg::lane_mask_t issue_mask,
	output logic commit_valid,
	output vector_pkg::reg_idx_t commit_reg,
	output vector_pkg::vector_t commit_value,
	output vector_pkg::lane_mask_t commit_mask
);

	vector_pkg::reg_idx_t read_sel1;
	vector_pkg::reg_idx_t read_sel2;
	vector_pkg::vector_t read_value1;
	vector_pkg::vector_t read_value2;

	logic ex_valid;
	instr_pkg::vec_op_t ex_op;
	vector_pkg::reg_idx_t ex_dest;
	vector_pkg::lane_mask_t ex_mask;
	logic ex_use_imm;
	vector_pkg::lane_t ex_imm;

	logic wb_valid;
	vector_pkg::reg_idx_t wb_reg;
	vector_pkg::vector_t wb_value;
	vector_pkg::lane_mask_t wb_mask;

	operand_decode u_operand_decode
	(
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue_strand(issue_strand),
		.issue_instr(issue_instr),
		.issue_mask(issue_mask),
		.read_sel1(read_sel1),
		.read_sel2(read_sel2),
		.ex_valid(ex_valid),
		.ex_op(ex_op),
		.ex_dest(ex_dest),
		.ex_mask(ex_mask),
		.ex_use_imm(ex_use_imm),
		.ex_imm(ex_imm)
	);

	// write-back stage drives the write port directly
	vector_register_file u_vector_register_file
	(
		.clk(clk),
		.read_sel1(read_sel1),
		.read_sel2(read_sel2),
		.read_value1(read_value1),
		.read_value2(read_value2),
		.write_enable(wb_valid),
		.write_reg(wb_reg),
		.write_value(wb_value),
		.write_mask(wb_mask)
	);

	vector_lane_alu u_vector_lane_alu
	(
		.clk(clk),
		.rst(rst),
		.ex_valid(ex_valid),
		.ex_op(ex_op),
		.ex_dest(ex_dest),
		.ex_mask(ex_mask),
		.ex_use_imm(ex_use_imm),
		.ex_imm(ex_imm),
		.operand1(read_value1),
		.operand2(read_value2),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_value(wb_value),
		.wb_mask(wb_mask)
	);

	assign commit_valid = wb_valid;
	assign commit_reg = wb_reg;
	assign commit_value = wb_value;
	assign commit_mask = wb_mask;

endmodule

`default_nettype wire

// ==== verilog/vector_lane_alu.sv ====
// Vector lane ALU
// Sixteen identical 32-bit lanes apply the decoded operation side by
// side. In the immediate format the sign-extended immediate is the
// second operand of every lane. The result is registered together with
// its destination and lane mask and feeds both the register-file write
// port and the commit outputs.

`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module vector_lane_alu
(
	input wire logic clk,
	input wire logic rst,
	input wire logic ex_valid,
	input instr_pkg::vec_op_t ex_op,
	input vector_pkg::reg_idx_t ex_dest,
	input vector_pkg::lane_mask_t ex_mask,
	input wire logic ex_use_imm,
	input vector_pkg::lane_t ex_imm,
	input vector_pkg::vector_t operand1,
	input vector_pkg::vector_t operand2,
	output logic wb_valid,
	output vector_pkg::reg_idx_t wb_reg,
	output vector_pkg::vector_t wb_value,
	output vector_pkg::lane_mask_t wb_mask
);

	localparam int SHAMT_W = $clog2(`VEC_LANE_WIDTH);

	vector_pkg::vector_t lane_result;

	for (genvar lane = 0; lane < `VEC_NUM_LANES; lane++)
	begin : g_lane
		vector_pkg::lane_t src_a;
		vector_pkg::lane_t src_b;
		vector_pkg::lane_t res;
		logic less;

		assign src_a = operand1[lane];
		assign src_b = ex_use_imm ? ex_imm : operand2[lane];

		assign less = $signed(src_a) < $signed(src_b);

		always_comb
		begin
			case (ex_op)
				instr_pkg::OP_ADD:  res = src_a + src_b;
				instr_pkg::OP_SUB:  res = src_a - src_b;
				instr_pkg::OP_AND:  res = src_a & src_b;
				instr_pkg::OP_OR:   res = src_a | src_b;
				instr_pkg::OP_XOR:  res = src_a ^ src_b;
				// move copies the second operand, src2 or the immediate
				instr_pkg::OP_MOVE: res = src_b;
				instr_pkg::OP_SHL:  res = src_a << src_b[SHAMT_W-1:0];
				instr_pkg::OP_SLT:  res = {{(`VEC_LANE_WIDTH - 1){1'b0}}, less};
				// unassigned codes are screened at decode
				default:            res = '0;
			endcase
		end

		assign lane_result[lane] = res;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_valid;
	end

	always_ff @(posedge clk)
	begin
		wb_reg <= ex_dest;
		wb_value <= lane_result;
		wb_mask <= ex_mask;
	end

endmodule

`default_nettype wire

// ==== verilog/vector_pkg.sv ====
// Vector datapath types
// Lane, vector, lane mask and physical register index types used on
// every port between decode, register file and lane ALU.

`default_nettype none

`include "vector_cfg.svh"

package vector_pkg;

	// one 32-bit lane value
	typedef logic [`VEC_LANE_WIDTH-1:0] lane_t;

	// a full vector register, lane 0 sits in the low bits
	typedef lane_t [`VEC_NUM_LANES-1:0] vector_t;

	// bit i enables a write to lane i
	typedef logic [`VEC_NUM_LANES-1:0] lane_mask_t;

	// physical register index, strand number in the upper bits and the
	// architectural register number below it
	typedef logic [`VEC_REG_IDX_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== verilog/vector_register_file.sv ====
// Vector register file
// 128 vector registers, 32 for each of the four strands, with two
// registered read ports and one write port. The write mask picks which
// lanes of the destination change; the other lanes keep their value.
// Storage is one word array per lane.

`timescale 1ns/1ps
`default_nettype none

`include "vector_cfg.svh"

module vector_register_file
(
	input wire logic clk,
	input vector_pkg::reg_idx_t read_sel1,
	input vector_pkg::reg_idx_t read_sel2,
	output vector_pkg::vector_t read_value1,
	output vector_pkg::vector_t read_value2,
	input wire logic write_enable,
	input vector_pkg::reg_idx_t write_reg,
	input vector_pkg::vector_t write_value,
	input vector_pkg::lane_mask_t write_mask
);

	for (genvar lane = 0; lane < `VEC_NUM_LANES; lane++)
	begin : g_lane
		vector_pkg::lane_t lane_mem [0:`VEC_NUM_REGS-1];

		// contents start at zero in simulation, rst does not touch them
		initial
		begin
			for (int i = 0; i < `VEC_NUM_REGS; i++)
				lane_mem[i] = '0;
		end

		// a read and a write to the same register at one edge returns
		// the old contents
		always_ff @(posedge clk)
		begin
			read_value1[lane] <= lane_mem[read_sel1];
			read_value2[lane] <= lane_mem[read_sel2];
		end

		always_ff @(posedge clk)
		begin
			if (write_enable && write_mask[lane])
				lane_mem[write_reg] <= write_value[lane];
		end
	end

endmodule

`default_nettype wire
